// File: files.f
+incdir+include
hdl/cpu_isa_pkg.sv
hdl/cpu_core_pkg.sv
hdl/alu8.sv
hdl/insn_decode.sv
hdl/cpu_control.sv
hdl/reg_file.sv
hdl/cpu_top.sv
dv/clk_gen.sv
dv/cpu_assert.sv
dv/cpu_tb.sv

// File: Makefile
TOP = cpu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timing -Iinclude -f files.f --top-module $(TOP) -j 0

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Iinclude -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: dv/cpu_tb.sv
// cpu testbench: memory model, directed program tests and write-back checks
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_tb import cpu_isa_pkg::*; ();

  localparam int TEST_CNT = 6;
  localparam int MAX_CYC  = 80;  // longest program, in cycles
  localparam int WD_NS    = 2 * TEST_CNT * MAX_CYC * 40 + TEST_CNT * 14 * 40;

  logic               CLK;
  logic               R;
  logic               rst_req;
  logic [`DATA_W-1:0] mem_rdata;
  logic [`ADDR_W-1:0] mem_addr;
  logic [`DATA_W-1:0] mem_wdata;
  logic               mem_we;
  logic [`DATA_W-1:0] mem [0:65535];

  logic [7:0]  prog[$];
  logic [15:0] exp_a[$];
  logic [7:0]  exp_d[$];
  logic [7:0]  poke_a[$];
  logic [7:0]  poke_d[$];
  int          cyc;

  clk_gen clk_gen_i (.rst_req(rst_req), .CLK(CLK), .R(R));

  cpu_top cpu_top_i (
    .CLK       (CLK),
    .R         (R),
    .mem_rdata (mem_rdata),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_we    (mem_we)
  );

  assign mem_rdata = mem[mem_addr]; // combinational read

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("ERR %0t: %s (got %0h, expected %0h)", $time, msg, got, exp);
      $display("Checks failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [7:0] rnd8();
    return 8'($urandom);
  endfunction

  task automatic new_prog();
    prog.delete();
    exp_a.delete();
    exp_d.delete();
    poke_a.delete();
    poke_d.delete();
    cyc = 0;
  endtask

  task automatic op_imp(input logic [7:0] op, input int n);
    prog.push_back(op);
    cyc += n;
  endtask

  task automatic op_imm(input logic [7:0] op, input logic [7:0] v);
    prog.push_back(op);
    prog.push_back(v);
    cyc += 2;
  endtask

  task automatic op_zp(input logic [7:0] op, input logic [7:0] a);
    prog.push_back(op);
    prog.push_back(a);
    cyc += 3;
  endtask

  task automatic op_jmp(input logic [15:0] t);
    prog.push_back(OP_JMP_ABS);
    prog.push_back(t[7:0]);
    prog.push_back(t[15:8]);
    cyc += 3;
  endtask

  task automatic poke(input logic [7:0] a, input logic [7:0] d);
    poke_a.push_back(a);
    poke_d.push_back(d);
  endtask

  // store instruction plus the write it must produce
  task automatic store(input logic [7:0] op, input logic [7:0] a, input logic [7:0] d);
    op_zp(op, a);
    exp_a.push_back({8'h00, a});
    exp_d.push_back(d);
  endtask

  task automatic apply_reset();
    @(posedge CLK);
    rst_req <= 1'b1;
    @(posedge CLK);
    rst_req <= 1'b0;
    @(negedge CLK);
    while (R) begin
      check(32'(mem_we), 0, "mem_we during reset");
      @(negedge CLK);
    end
    check(32'(mem_addr), 32'(`RESET_PC), "first fetch address");
  endtask

  task automatic run_prog(input string name);
    logic [15:0] got_a[$];
    logic [7:0]  got_d[$];
    logic [15:0] here;
    here = 16'(prog.size());
    op_jmp(here); // park on itself
    for (int i = 0; i < 65536; i++)
      mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'hA5;
    foreach (prog[i])
      mem[i] = prog[i];
    foreach (poke_a[i])
      mem[16'(poke_a[i])] = poke_d[i];
    apply_reset();
    repeat (cyc + 4) begin
      @(negedge CLK); // bus stable mid cycle
      if (mem_we) begin
        got_a.push_back(mem_addr);
        got_d.push_back(mem_wdata);
        mem[mem_addr] = mem_wdata;
      end
    end
    check(32'(got_a.size()), 32'(exp_a.size()), {name, ": write count"});
    foreach (exp_a[i]) begin
      check(32'(got_a[i]), 32'(exp_a[i]), {name, ": write address"});
      check(32'(got_d[i]), 32'(exp_d[i]), {name, ": write data"});
    end
  endtask

  task automatic test_reset();
    new_prog();
    run_prog("reset");
  endtask

  task automatic test_load_store();
    logic [7:0] v[6];
    foreach (v[i])
      v[i] = rnd8();
    new_prog();
    op_imm(OP_LDA_IMM, v[0]);
    store(OP_STA_ZP, 8'h80, v[0]);
    op_imm(OP_LDX_IMM, v[1]);
    store(OP_STX_ZP, 8'h81, v[1]);
    op_imm(OP_LDY_IMM, v[2]);
    store(OP_STY_ZP, 8'h82, v[2]);
    poke(8'h90, v[3]);
    poke(8'h91, v[4]);
    poke(8'h92, v[5]);
    op_zp(OP_LDA_ZP, 8'h90);
    store(OP_STA_ZP, 8'h83, v[3]);
    op_zp(OP_LDX_ZP, 8'h91);
    store(OP_STX_ZP, 8'h84, v[4]);
    op_zp(OP_LDY_ZP, 8'h92);
    store(OP_STY_ZP, 8'h85, v[5]);
    run_prog("load/store");
  endtask

  function automatic logic [7:0] logic_result(input int k, input logic [7:0] a,
                                              input logic [7:0] b);
    case (k)
      0:       return a | b;
      1:       return a & b;
      default: return a ^ b;
    endcase
  endfunction

  task automatic test_logic();
    logic [7:0] ops_imm [3] = '{OP_ORA_IMM, OP_AND_IMM, OP_EOR_IMM};
    logic [7:0] ops_zp  [3] = '{OP_ORA_ZP, OP_AND_ZP, OP_EOR_ZP};
    logic [7:0] a;
    logic [7:0] b;
    new_prog();
    for (int k = 0; k < 3; k++) begin
      a = rnd8();
      b = rnd8();
      op_imm(OP_LDA_IMM, a);
      op_imm(ops_imm[k], b);
      store(OP_STA_ZP, 8'(8'h80 + k * 2), logic_result(k, a, b));
      a = rnd8();
      b = rnd8();
      poke(8'(8'h90 + k), b);
      op_imm(OP_LDA_IMM, a);
      op_zp(ops_zp[k], 8'(8'h90 + k));
      store(OP_STA_ZP, 8'(8'h81 + k * 2), logic_result(k, a, b));
    end
    run_prog("logic");
  endtask

  task automatic test_arith();
    logic [7:0]  a;
    logic [7:0]  b;
    logic [7:0]  c;
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] s;
    a = rnd8();
    b = rnd8();
    c = rnd8();
    x = {rnd8(), 8'hF0 | rnd8()}; // low bytes always carry
    y = {rnd8(), 8'h80 | rnd8()};
    s = x + y;
    new_prog();
    op_imp(OP_SEC, 1); // so the clc has something to clear
    op_imp(OP_CLC, 1);
    op_imm(OP_LDA_IMM, a);
    op_imm(OP_ADC_IMM, b);
    store(OP_STA_ZP, 8'h80, 8'(a + b));
    poke(8'h90, c);
    op_imp(OP_SEC, 1);
    op_imm(OP_LDA_IMM, a);
    op_zp(OP_SBC_ZP, 8'h90);
    store(OP_STA_ZP, 8'h81, 8'(a - c));
    op_imp(OP_CLC, 1);
    op_imm(OP_LDA_IMM, x[7:0]);
    op_imm(OP_ADC_IMM, y[7:0]);
    store(OP_STA_ZP, 8'h82, s[7:0]);
    op_imm(OP_LDA_IMM, x[15:8]);
    op_imm(OP_ADC_IMM, y[15:8]);
    store(OP_STA_ZP, 8'h83, s[15:8]);
    run_prog("arith");
  endtask

  task automatic test_regs();
    logic [7:0] v;
    logic [7:0] w;
    logic [7:0] u;
    v = rnd8();
    w = rnd8();
    u = rnd8();
    new_prog();
    op_imm(OP_LDX_IMM, 8'hFF);
    op_imp(OP_INX, 2);
    store(OP_STX_ZP, 8'h80, 8'h00);
    op_imp(OP_DEX, 2);
    store(OP_STX_ZP, 8'h81, 8'hFF);
    op_imm(OP_LDY_IMM, 8'h00);
    op_imp(OP_DEY, 2);
    store(OP_STY_ZP, 8'h82, 8'hFF);
    op_imp(OP_INY, 2);
    store(OP_STY_ZP, 8'h83, 8'h00);
    op_imm(OP_LDA_IMM, v);
    op_imp(OP_TAX, 2);
    store(OP_STX_ZP, 8'h84, v);
    op_imp(OP_TAY, 2);
    store(OP_STY_ZP, 8'h85, v);
    op_imm(OP_LDX_IMM, w);
    op_imp(OP_TXA, 2);
    store(OP_STA_ZP, 8'h86, w);
    op_imm(OP_LDY_IMM, u);
    op_imp(OP_TYA, 2);
    store(OP_STA_ZP, 8'h87, u);
    run_prog("registers");
  endtask

  task automatic test_flow();
    logic [7:0]  v;
    logic [15:0] t;
    v = rnd8();
    new_prog();
    op_imm(OP_LDA_IMM, v);
    t = 16'(prog.size()) + 16'd5;
    op_jmp(t);
    prog.push_back(OP_STA_ZP); // skipped store
    prog.push_back(8'h80);
    store(OP_STA_ZP, 8'h81, v);
    op_imp(8'h02, 1); // unknown code
    store(OP_STA_ZP, 8'h82, v);
    run_prog("control flow");
  endtask

  initial begin
    #(WD_NS);
    $display("Timeout: the tests did not finish within %0d ns", WD_NS);
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst_req = 1'b0;
    void'($urandom(85137));
    test_reset();
    test_load_store();
    test_logic();
    test_arith();
    test_regs();
    test_flow();
    $display("All checks passed");
    $finish;
  end

endmodule

// File: dv/cpu_assert.sv
// controller assertions: write strobe legality and store sequencing
`timescale 1ns/10ps

module cpu_assert import cpu_isa_pkg::*, cpu_core_pkg::*; (
  input logic   CLK,
  input logic   R,
  input insn_e  insn,
  input state_e state,
  input logic   mem_we
);

  // strobe only in the write cycle of a store opcode
  a_we_state: assert property (@(posedge CLK) disable iff (R)
    mem_we |-> state == ST_WRITE_DATA && $past(insn) == STORE)
    else $error("mem_we high outside the write cycle of a store");

  a_we_reset: assert property (@(posedge CLK) R |-> !mem_we)
    else $error("mem_we high while in reset");

  // store ends the instruction
  a_store_next: assert property (@(posedge CLK) disable iff (R)
    state == ST_WRITE_DATA |=> state == ST_FETCH)
    else $error("no return to ST_FETCH after a store");

endmodule

bind cpu_control cpu_assert cpu_assert_i (
  .CLK    (CLK),
  .R      (R),
  .insn   (insn),
  .state  (state),
  .mem_we (mem_we)
);

// File: dv/clk_gen.sv
// testbench clock and reset source: 40 ns clock, reset held for 10 cycles
`timescale 1ns/10ps

module clk_gen (
  input  logic rst_req, // restart the reset sequence
  output logic CLK,
  output logic R
);

  logic [3:0] rst_cnt = 4'd10; // reset also runs at time zero

  initial CLK = 1'b0;
  always #20 CLK = ~CLK;

  always @(posedge CLK) begin
    if (rst_req)
      rst_cnt <= 4'd10;
    else if (rst_cnt != 4'd0)
      rst_cnt <= rst_cnt - 4'd1;
  end

  assign R = (rst_cnt != 4'd0);

endmodule

// File: hdl/cpu_top.sv
// cpu top level: decoder, controller and register file on the memory ports
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_top (
  input  logic               CLK,
  input  logic               R,
  input  logic [`DATA_W-1:0] mem_rdata,
  output logic [`ADDR_W-1:0] mem_addr,
  output logic [`DATA_W-1:0] mem_wdata,
  output logic               mem_we
);

  logic [`DATA_W-1:0]     op_byte;
  cpu_isa_pkg::insn_e     insn;
  cpu_isa_pkg::amode_e    amode;
  cpu_isa_pkg::reg_sel_e  reg_sel;
  cpu_core_pkg::alu_op_e  alu_op;
  cpu_core_pkg::state_e   state;

  insn_decode insn_decode_i (
    .op_byte (op_byte),
    .insn    (insn),
    .amode   (amode),
    .reg_sel (reg_sel),
    .alu_op  (alu_op)
  );

  cpu_control cpu_control_i (
    .CLK       (CLK),
    .R         (R),
    .mem_rdata (mem_rdata),
    .insn      (insn),
    .amode     (amode),
    .op_byte   (op_byte),
    .state     (state),
    .mem_addr  (mem_addr),
    .mem_we    (mem_we)
  );

  reg_file reg_file_i (
    .CLK       (CLK),
    .R         (R),
    .state     (state),
    .insn      (insn),
    .reg_sel   (reg_sel),
    .alu_op    (alu_op),
    .op_byte   (op_byte),
    .mem_rdata (mem_rdata),
    .mem_wdata (mem_wdata)
  );

endmodule

// File: hdl/reg_file.sv
// register file: a, x, y and carry, alu operand muxing and store data
`timescale 1ns/10ps
`include "cpu_consts.svh"

module reg_file import cpu_isa_pkg::*, cpu_core_pkg::*; (
  input  logic               CLK,
  input  logic               R,
  input  state_e             state,
  input  insn_e              insn,
  input  reg_sel_e           reg_sel,
  input  alu_op_e            alu_op,
  input  logic [`DATA_W-1:0] op_byte,
  input  logic [`DATA_W-1:0] mem_rdata,
  output logic [`DATA_W-1:0] mem_wdata
);

  logic [`DATA_W-1:0] reg_a;
  logic [`DATA_W-1:0] reg_x;
  logic [`DATA_W-1:0] reg_y;
  logic [`FLAG_C:0]   reg_p;
  logic [`DATA_W-1:0] sel_val;
  logic [`DATA_W-1:0] src_val;
  logic [`DATA_W-1:0] alu_a;
  logic [`DATA_W-1:0] alu_y;
  logic [`DATA_W-1:0] wr_data;
  logic               alu_cout;
  logic               wr_en;
  logic               arith;

  always_comb begin
    case (reg_sel)
      REG_X:   sel_val = reg_x;
      REG_Y:   sel_val = reg_y;
      default: sel_val = reg_a;
    endcase
  end

  // txa / tya pick x or y by opcode bit 4
  assign src_val = (reg_sel != REG_A) ? reg_a : (op_byte[4] ? reg_y : reg_x);
  assign alu_a   = (insn == TRANSFER) ? src_val : sel_val;

  alu8 alu8_i (
    .a    (alu_a),
    .b    (mem_rdata),
    .cin  (reg_p[`FLAG_C]),
    .op   (alu_op),
    .y    (alu_y),
    .cout (alu_cout)
  );

  assign wr_en   = state == ST_LOAD_REG && (insn inside {LOAD, ALU, INCDEC, TRANSFER});
  assign wr_data = (insn == LOAD) ? mem_rdata : alu_y;
  assign arith   = insn == ALU && (alu_op == ALU_ADD || alu_op == ALU_SUB);
  assign mem_wdata = sel_val;

  always_ff @(posedge CLK or posedge R) begin
    if (R) begin
      reg_a <= '0;
      reg_x <= '0;
      reg_y <= '0;
      reg_p <= '0;
    end else begin
      if (wr_en) begin
        case (reg_sel)
          REG_X:   reg_x <= wr_data;
          REG_Y:   reg_y <= wr_data;
          default: reg_a <= wr_data;
        endcase
      end
      if (state == ST_LOAD_REG && arith)
        reg_p[`FLAG_C] <= alu_cout;
      else if (state == ST_FETCH && insn == SETFLAG)
        reg_p[`FLAG_C] <= op_byte[5]; // clc / sec
    end
  end

endmodule

// File: hdl/cpu_control.sv
// cpu controller: state machine, program counter, opcode and address registers
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_control import cpu_isa_pkg::*, cpu_core_pkg::*; (
  input  logic               CLK,
  input  logic               R,
  input  logic [`DATA_W-1:0] mem_rdata,
  input  insn_e              insn,
  input  amode_e             amode,
  output logic [`DATA_W-1:0] op_byte,
  output state_e             state,
  output logic [`ADDR_W-1:0] mem_addr,
  output logic               mem_we
);

  logic [`ADDR_W-1:0] pc;
  logic [`DATA_W-1:0] op_reg;
  logic [`DATA_W-1:0] lo_reg;
  logic [`ADDR_W-1:0] zp_addr;
  logic               pc_inc;
  state_e             next_state;

  // decode straight off the bus during fetch
  assign op_byte = (state == ST_FETCH) ? mem_rdata : op_reg;
  assign zp_addr = {{(`ADDR_W - `DATA_W){1'b0}}, lo_reg};

  always_comb begin
    case (state)
      ST_LOAD_REG:   mem_addr = (amode == ZP) ? zp_addr : pc;
      ST_WRITE_DATA: mem_addr = zp_addr;
      default:       mem_addr = pc;
    endcase
  end

  assign mem_we = (state == ST_WRITE_DATA);

  // step past every opcode and operand byte read
  assign pc_inc = state == ST_FETCH || state == ST_LO_BYTE ||
                  (state == ST_LOAD_REG && amode == IMM);

  always_comb begin
    case (state)
      ST_FETCH: begin
        case (insn)
          SETFLAG, NOP:     next_state = ST_FETCH;
          INCDEC, TRANSFER: next_state = ST_LOAD_REG;
          LOAD, ALU:        next_state = (amode == IMM) ? ST_LOAD_REG : ST_LO_BYTE;
          default:          next_state = ST_LO_BYTE; // store, jmp
        endcase
      end
      ST_LO_BYTE: begin
        case (insn)
          STORE:   next_state = ST_WRITE_DATA;
          JMP:     next_state = ST_HI_BYTE;
          default: next_state = ST_LOAD_REG;
        endcase
      end
      default: next_state = ST_FETCH;
    endcase
  end

  always_ff @(posedge CLK or posedge R) begin
    if (R) begin
      state <= ST_FETCH;
      pc    <= `RESET_PC;
    end else begin
      state <= next_state;
      if (state == ST_HI_BYTE)
        pc <= {mem_rdata, lo_reg}; // jump target
      else if (pc_inc)
        pc <= pc + `ADDR_W'(1);
    end
  end

  always_ff @(posedge CLK) begin
    if (state == ST_FETCH)
      op_reg <= mem_rdata;
    if (state == ST_LO_BYTE)
      lo_reg <= mem_rdata; // zp address or jmp low byte
  end

endmodule

// File: hdl/insn_decode.sv
// opcode decoder: class, addressing mode, register and alu operation per opcode
`timescale 1ns/10ps
`include "cpu_consts.svh"

module insn_decode import cpu_isa_pkg::*, cpu_core_pkg::*; (
  input  logic [`DATA_W-1:0] op_byte,
  output insn_e              insn,
  output amode_e             amode,
  output reg_sel_e           reg_sel,
  output alu_op_e            alu_op
);

  // class and mode
  always_comb begin
    insn  = NOP;
    amode = IMPLIED;
    case (op_byte)
      OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM: begin
        insn  = LOAD;
        amode = IMM;
      end
      OP_LDA_ZP, OP_LDX_ZP, OP_LDY_ZP: begin
        insn  = LOAD;
        amode = ZP;
      end
      OP_STA_ZP, OP_STX_ZP, OP_STY_ZP: begin
        insn  = STORE;
        amode = ZP;
      end
      OP_ORA_IMM, OP_AND_IMM, OP_EOR_IMM, OP_ADC_IMM, OP_SBC_IMM: begin
        insn  = ALU;
        amode = IMM;
      end
      OP_ORA_ZP, OP_AND_ZP, OP_EOR_ZP, OP_ADC_ZP, OP_SBC_ZP: begin
        insn  = ALU;
        amode = ZP;
      end
      OP_INX, OP_INY, OP_DEX, OP_DEY: insn = INCDEC;
      OP_TAX, OP_TXA, OP_TAY, OP_TYA: insn = TRANSFER;
      OP_CLC, OP_SEC:                 insn = SETFLAG;
      OP_JMP_ABS: begin
        insn  = JMP;
        amode = ABS;
      end
      OP_NOP:  insn = NOP;
      default: insn = NOP; // unknown codes do nothing
    endcase
  end

  // named register, transfers give their destination
  always_comb begin
    case (op_byte)
      OP_LDX_IMM, OP_LDX_ZP, OP_STX_ZP, OP_INX, OP_DEX, OP_TAX: reg_sel = REG_X;
      OP_LDY_IMM, OP_LDY_ZP, OP_STY_ZP, OP_INY, OP_DEY, OP_TAY: reg_sel = REG_Y;
      default:                                                  reg_sel = REG_A;
    endcase
  end

  always_comb begin
    case (op_byte)
      OP_ORA_IMM, OP_ORA_ZP: alu_op = ALU_OR;
      OP_AND_IMM, OP_AND_ZP: alu_op = ALU_AND;
      OP_EOR_IMM, OP_EOR_ZP: alu_op = ALU_EOR;
      OP_ADC_IMM, OP_ADC_ZP: alu_op = ALU_ADD;
      OP_SBC_IMM, OP_SBC_ZP: alu_op = ALU_SUB;
      OP_INX, OP_INY:        alu_op = ALU_INC;
      OP_DEX, OP_DEY:        alu_op = ALU_DEC;
      default:               alu_op = ALU_PASS; // transfers, setflag
    endcase
  end

endmodule

// File: hdl/alu8.sv
// 8-bit alu: logic ops, add and subtract with carry, increment and decrement
`timescale 1ns/10ps
`include "cpu_consts.svh"

module alu8 import cpu_core_pkg::*; (
  input  logic [`DATA_W-1:0] a,
  input  logic [`DATA_W-1:0] b,
  input  logic               cin,
  input  alu_op_e            op,
  output logic [`DATA_W-1:0] y,
  output logic               cout
);

  logic [`DATA_W-1:0] add_b;
  logic               add_c;
  logic [`DATA_W:0]   sum;

  // one adder serves add, sub, inc and dec
  always_comb begin
    case (op)
      ALU_SUB: begin
        add_b = ~b; // carry set means no borrow
        add_c = cin;
      end
      ALU_INC: begin
        add_b = '0;
        add_c = 1'b1;
      end
      ALU_DEC: begin
        add_b = '1;
        add_c = 1'b0;
      end
      default: begin
        add_b = b;
        add_c = cin;
      end
    endcase
  end

  assign sum = {1'b0, a} + {1'b0, add_b} + {{`DATA_W{1'b0}}, add_c};

  always_comb begin
    case (op)
      ALU_PASS: y = a;
      ALU_OR:   y = a | b;
      ALU_AND:  y = a & b;
      ALU_EOR:  y = a ^ b;
      default:  y = sum[`DATA_W-1:0];
    endcase
  end

  assign cout = (op == ALU_ADD || op == ALU_SUB) && sum[`DATA_W];

endmodule

// File: hdl/cpu_core_pkg.sv
// core internal types: controller states and alu operations

package cpu_core_pkg;

  // controller states, one cycle each
  typedef enum logic [2:0] {
    ST_FETCH,      // opcode read at pc
    ST_LO_BYTE,    // operand / low address byte
    ST_HI_BYTE,    // jmp high byte
    ST_LOAD_REG,   // register write back
    ST_WRITE_DATA  // store strobe
  } state_e;

  typedef enum logic [2:0] {
    ALU_PASS,
    ALU_OR,
    ALU_AND,
    ALU_EOR,
    ALU_ADD,  // a + b + cin
    ALU_SUB,  // a + ~b + cin
    ALU_INC,
    ALU_DEC
  } alu_op_e;

endpackage

// File: hdl/cpu_isa_pkg.sv
// instruction set types: opcodes, instruction classes, addressing modes, registers
`include "cpu_consts.svh"

package cpu_isa_pkg;

  typedef enum logic [`DATA_W-1:0] {
    OP_LDA_IMM = 8'hA9, OP_LDA_ZP = 8'hA5,
    OP_LDX_IMM = 8'hA2, OP_LDX_ZP = 8'hA6,
    OP_LDY_IMM = 8'hA0, OP_LDY_ZP = 8'hA4,
    OP_STA_ZP  = 8'h85, OP_STX_ZP = 8'h86, OP_STY_ZP = 8'h84,
    OP_ORA_IMM = 8'h09, OP_ORA_ZP = 8'h05,
    OP_AND_IMM = 8'h29, OP_AND_ZP = 8'h25,
    OP_EOR_IMM = 8'h49, OP_EOR_ZP = 8'h45,
    OP_ADC_IMM = 8'h69, OP_ADC_ZP = 8'h65,
    OP_SBC_IMM = 8'hE9, OP_SBC_ZP = 8'hE5,
    OP_INX     = 8'hE8, OP_INY    = 8'hC8,
    OP_DEX     = 8'hCA, OP_DEY    = 8'h88,
    OP_TAX     = 8'hAA, OP_TXA    = 8'h8A,
    OP_TAY     = 8'hA8, OP_TYA    = 8'h98,
    OP_CLC     = 8'h18, OP_SEC    = 8'h38, // bit 5 gives the new carry
    OP_JMP_ABS = 8'h4C,
    OP_NOP     = 8'hEA
  } opcode_e;

  typedef enum logic [2:0] {
    LOAD, STORE, ALU, INCDEC, TRANSFER, SETFLAG, JMP, NOP
  } insn_e;

  typedef enum logic [1:0] {
    IMPLIED, IMM, ZP, ABS
  } amode_e;

  // for transfers this is the destination
  typedef enum logic [1:0] {
    REG_A, REG_X, REG_Y
  } reg_sel_e;

endpackage

// File: include/cpu_consts.svh
// cpu core constants: bus widths, reset vector and status flag layout
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// address bus, 64 KiB space
`define ADDR_W 16

// data bus and register width
`define DATA_W 8

// first fetch address after reset
`define RESET_PC 16'h0000

// carry position in the status byte
// the other 6502 flags have no reader here
`define FLAG_C 0

`endif
